// ==== rtl/frontend_pkg.sv ====
package frontend_pkg;

  ////////////////////////////////////////
  // Architectural widths
  ////////////////////////////////////////

  localparam int XLEN      = 32; // PC and instruction word
  localparam int ARF_WIDTH = 5;  // Architectural register number
  localparam int ARF_COUNT = 32; // x0 to x31

  ////////////////////////////////////////
  // Opcode classes
  ////////////////////////////////////////

  // One class per RISC-V major opcode group that the back end cares about
  typedef enum logic [2:0] {
    OP_ALU    = 3'd0, // Register-register arithmetic
    OP_ALUI   = 3'd1, // Register-immediate arithmetic
    OP_LOAD   = 3'd2, // Loads
    OP_STORE  = 3'd3, // Stores, no destination
    OP_BRANCH = 3'd4, // Conditional branches, no destination
    OP_LUI    = 3'd5, // Upper immediate
    OP_JAL    = 3'd6, // Jump and link
    OP_OTHER  = 3'd7  // Anything else, never writes
  } opcode_e;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // The addi x0 NOP

endpackage

// ==== rtl/rename_bus_if.sv ====
`timescale 1ns/1ps

interface rename_bus_if;
  import frontend_pkg::*;

  logic                 valid;     // Decode register holds an instruction
  logic [XLEN-1:0]      pc;        // PC of that instruction
  opcode_e              opcode;    // Opcode class
  logic [ARF_WIDTH-1:0] rd;        // Destination field
  logic [ARF_WIDTH-1:0] rs1;       // First source field
  logic [ARF_WIDTH-1:0] rs2;       // Second source field
  logic                 writes_rd; // Needs a new physical register

  // Decode side drives everything
  modport decoder (
    output valid, pc, opcode, rd, rs1, rs2, writes_rd
  );

  // Rename side only samples
  modport renamer (
    input valid, pc, opcode, rd, rs1, rs2, writes_rd
  );

endinterface

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
  parameter logic [frontend_pkg::XLEN-1:0] BOOT_PC = '0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          stall,
  input  logic                          flush,
  input  logic [frontend_pkg::XLEN-1:0] flush_pc,
  input  logic [frontend_pkg::XLEN-1:0] imem_data,
  output logic [frontend_pkg::XLEN-1:0] imem_addr,
  output logic                          fetch_valid,
  output logic [frontend_pkg::XLEN-1:0] fetch_pc,
  output logic [frontend_pkg::XLEN-1:0] fetch_instr
);
  import frontend_pkg::*;

  logic [XLEN-1:0] pc; // Program counter

  assign imem_addr = pc; // Memory answers in the same cycle

  ////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= BOOT_PC;
    end else if (flush) begin
      pc <= flush_pc; // Redirect wins over stall
    end else if (!stall) begin
      pc <= pc + XLEN'(4); // Sequential fetch
    end
  end

  ////////////////////////////////////////
  // Fetch pipeline register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      fetch_valid <= 1'b0;
      fetch_instr <= NOP_INSTR; // Cleared slot decodes as a harmless NOP
    end else if (!stall) begin
      fetch_valid <= 1'b1;
      fetch_instr <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      fetch_pc <= pc; // Payload, qualified by fetch_valid
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00) // Also relies on flush_pc from outside
    else $error("fetch_stage: PC lost word alignment");

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          stall,
  input  logic                          flush,
  input  logic                          fetch_valid,
  input  logic [frontend_pkg::XLEN-1:0] fetch_pc,
  input  logic [frontend_pkg::XLEN-1:0] fetch_instr,
  rename_bus_if.decoder                 bus
);
  import frontend_pkg::*;

  opcode_e              dec_opcode; // Class of the fetched word
  logic [ARF_WIDTH-1:0] dec_rd;
  logic [ARF_WIDTH-1:0] dec_rs1;
  logic [ARF_WIDTH-1:0] dec_rs2;
  logic                 dec_writes; // Writing class with nonzero rd

  ////////////////////////////////////////
  // Field extraction and classification
  ////////////////////////////////////////

  assign dec_rd  = fetch_instr[11:7];  // Standard RISC-V positions
  assign dec_rs1 = fetch_instr[19:15];
  assign dec_rs2 = fetch_instr[24:20];

  always_comb begin
    case (fetch_instr[6:0])
      7'b0110011: dec_opcode = OP_ALU;    // OP
      7'b0010011: dec_opcode = OP_ALUI;   // OP-IMM, includes the NOP
      7'b0000011: dec_opcode = OP_LOAD;   // LOAD
      7'b0100011: dec_opcode = OP_STORE;  // STORE
      7'b1100011: dec_opcode = OP_BRANCH; // BRANCH
      7'b0110111: dec_opcode = OP_LUI;    // LUI
      7'b1101111: dec_opcode = OP_JAL;    // JAL
      default:    dec_opcode = OP_OTHER;  // JALR, AUIPC, system and junk
    endcase
  end

  always_comb begin
    case (dec_opcode)
      OP_ALU, OP_ALUI, OP_LOAD, OP_LUI, OP_JAL: begin
        dec_writes = (dec_rd != '0); // x0 is never renamed
      end
      default: begin
        dec_writes = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Decode pipeline register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      bus.valid     <= 1'b0;
      bus.writes_rd <= 1'b0;
    end else if (!stall) begin
      bus.valid     <= fetch_valid;
      bus.writes_rd <= fetch_valid && dec_writes; // Bubbles never allocate
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      bus.pc     <= fetch_pc;
      bus.opcode <= dec_opcode;
      bus.rd     <= dec_rd;
      bus.rs1    <= dec_rs1;
      bus.rs2    <= dec_rs2;
    end
  end

  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    bus.writes_rd |-> (bus.valid && bus.rd != '0))
    else $error("decode_stage: writes_rd raised for x0 or a bubble");

endmodule

// ==== rtl/free_list.sv ====
`timescale 1ns/1ps

module free_list #(
  parameter  int PRF_COUNT = 64,
  localparam int PRF_WIDTH = $clog2(PRF_COUNT)
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pop,       // Take head this edge
  input  logic                 push,      // Return a register this edge
  input  logic [PRF_WIDTH-1:0] push_preg,
  output logic [PRF_WIDTH-1:0] head_preg, // Valid while not empty
  output logic                 empty
);
  import frontend_pkg::*;

  localparam int DEPTH     = PRF_COUNT - ARF_COUNT; // At most this many free at once
  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  logic [PRF_WIDTH-1:0] mem [DEPTH]; // Circular storage
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [CNT_WIDTH-1:0] count;       // Registers currently free
  logic                 full;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_preg = mem[rd_ptr];
  assign empty     = (count == '0);
  assign full      = (count == CNT_WIDTH'(DEPTH));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= PRF_WIDTH'(ARF_COUNT + i); // Ascending, above the identity map
      end
      rd_ptr <= '0;
      wr_ptr <= '0; // Full, so tail sits on head
      count  <= CNT_WIDTH'(DEPTH);
    end else begin
      if (push) begin
        mem[wr_ptr] <= push_preg;
        wr_ptr      <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
    else $error("free_list: pop while empty");

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
    else $error("free_list: retire pushed into a full list");

endmodule

// ==== rtl/rename_stage.sv ====
`timescale 1ns/1ps

module rename_stage #(
  parameter  int PRF_COUNT = 64,
  localparam int PRF_WIDTH = $clog2(PRF_COUNT)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush,
  input  logic                          dispatch_ready,
  input  logic                          retire_valid,
  input  logic [PRF_WIDTH-1:0]          retire_preg,
  rename_bus_if.renamer                 bus,
  output logic                          stall,
  output logic                          ren_valid,
  output logic [frontend_pkg::XLEN-1:0] ren_pc,
  output frontend_pkg::opcode_e         ren_opcode,
  output logic [PRF_WIDTH-1:0]          ren_prd,
  output logic [PRF_WIDTH-1:0]          ren_prs1,
  output logic [PRF_WIDTH-1:0]          ren_prs2,
  output logic [PRF_WIDTH-1:0]          ren_pold
);
  import frontend_pkg::*;

  logic [PRF_WIDTH-1:0] rat [ARF_COUNT]; // Architectural to physical map
  logic [PRF_WIDTH-1:0] fl_head;         // Next free register
  logic                 fl_empty;
  logic                 wr_req;          // Bus instruction needs a register
  logic                 alloc;           // Rename actually happens this edge

  ////////////////////////////////////////
  // Stall and allocation
  ////////////////////////////////////////

  assign wr_req = bus.valid && bus.writes_rd;
  assign stall  = (ren_valid && !dispatch_ready) // Dispatch back-pressure
               || (wr_req && fl_empty);          // Nothing to allocate
  assign alloc  = wr_req && !stall && !flush;    // Flush blocks pop and RAT write

  free_list #(
    .PRF_COUNT (PRF_COUNT)
  ) u_free_list (
    .clk       (clk),
    .rst_n     (rst_n),
    .pop       (alloc),
    .push      (retire_valid), // Retire ignores stall and flush
    .push_preg (retire_preg),
    .head_preg (fl_head),
    .empty     (fl_empty)
  );

  ////////////////////////////////////////
  // Register alias table
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < ARF_COUNT; i++) begin
        rat[i] <= PRF_WIDTH'(i); // Identity map
      end
    end else if (alloc) begin
      rat[bus.rd] <= fl_head; // rd is never x0 here
    end
  end

  ////////////////////////////////////////
  // Rename output register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      ren_valid <= 1'b0;
    end else if (!stall) begin
      ren_valid <= bus.valid;
    end else if (dispatch_ready) begin
      // Free list stall while dispatch takes the current output
      ren_valid <= 1'b0; // Bubble so nothing is consumed twice
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ren_pc     <= bus.pc;
      ren_opcode <= bus.opcode;
      ren_prs1   <= rat[bus.rs1]; // Previous rename already landed in RAT
      ren_prs2   <= rat[bus.rs2];
      ren_prd    <= wr_req ? fl_head : '0;      // Zero for non-writers
      ren_pold   <= wr_req ? rat[bus.rd] : '0;  // Freed at retire
    end
  end

  a_x0_pinned: assert property (@(posedge clk) disable iff (!rst_n) rat[0] == '0)
    else $error("rename_stage: x0 mapping changed");

endmodule

// ==== rtl/rename_frontend.sv ====
`timescale 1ns/1ps

module rename_frontend #(
  parameter  int                          PRF_COUNT = 64,
  parameter  logic [frontend_pkg::XLEN-1:0] BOOT_PC = '0,
  localparam int                          PRF_WIDTH = $clog2(PRF_COUNT)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [frontend_pkg::XLEN-1:0] imem_data,
  input  logic                          dispatch_ready,
  input  logic                          flush,
  input  logic [frontend_pkg::XLEN-1:0] flush_pc,
  input  logic                          retire_valid,
  input  logic [PRF_WIDTH-1:0]          retire_preg,
  output logic [frontend_pkg::XLEN-1:0] imem_addr,
  output logic                          ren_valid,
  output logic [frontend_pkg::XLEN-1:0] ren_pc,
  output frontend_pkg::opcode_e         ren_opcode,
  output logic [PRF_WIDTH-1:0]          ren_prd,
  output logic [PRF_WIDTH-1:0]          ren_prs1,
  output logic [PRF_WIDTH-1:0]          ren_prs2,
  output logic [PRF_WIDTH-1:0]          ren_pold
);
  import frontend_pkg::*;

  logic            stall;       // Global, from rename
  logic            fetch_valid; // Fetch to decode
  logic [XLEN-1:0] fetch_pc;
  logic [XLEN-1:0] fetch_instr;

  rename_bus_if rn_bus (); // Decode to rename

  fetch_stage #(
    .BOOT_PC (BOOT_PC)
  ) u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .flush       (flush),
    .flush_pc    (flush_pc),
    .imem_data   (imem_data),
    .imem_addr   (imem_addr),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr)
  );

  decode_stage u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .flush       (flush),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .bus         (rn_bus.decoder)
  );

  rename_stage #(
    .PRF_COUNT (PRF_COUNT)
  ) u_rename (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .dispatch_ready (dispatch_ready),
    .retire_valid   (retire_valid),
    .retire_preg    (retire_preg),
    .bus            (rn_bus.renamer),
    .stall          (stall),
    .ren_valid      (ren_valid),
    .ren_pc         (ren_pc),
    .ren_opcode     (ren_opcode),
    .ren_prd        (ren_prd),
    .ren_prs1       (ren_prs1),
    .ren_prs2       (ren_prs2),
    .ren_pold       (ren_pold)
  );

endmodule

// ==== test/rename_model.svh ====
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

////////////////////////////////////////
// Reference RAT and free list
////////////////////////////////////////

logic [PRF_WIDTH-1:0] model_rat [ARF_COUNT]; // Architectural to physical
logic [PRF_WIDTH-1:0] model_free [$];        // Free registers, head at index 0

function automatic void model_reset();
  model_free.delete();
  for (int a = 0; a < ARF_COUNT; a++) begin
    model_rat[a] = PRF_WIDTH'(a); // Identity map
  end
  for (int p = ARF_COUNT; p < PRF_COUNT; p++) begin
    model_free.push_back(PRF_WIDTH'(p)); // Ascending above the identity map
  end
endfunction

// Class of a word, from its major opcode alone
function automatic opcode_e model_class(input logic [31:0] instr);
  case (instr[6:0])
    7'h33:   return OP_ALU;
    7'h13:   return OP_ALUI;
    7'h03:   return OP_LOAD;
    7'h23:   return OP_STORE;
    7'h63:   return OP_BRANCH;
    7'h37:   return OP_LUI;
    7'h6f:   return OP_JAL;
    default: return OP_OTHER;
  endcase
endfunction

// Destination needs a fresh register
function automatic logic model_writes(input logic [31:0] instr);
  return (model_class(instr) inside {OP_ALU, OP_ALUI, OP_LOAD, OP_LUI, OP_JAL})
      && (instr[11:7] != 5'd0); // x0 keeps physical 0
endfunction

`endif

// ==== test/tb_rename_frontend.sv ====
`timescale 1ns/1ps

module tb_rename_frontend;
  import frontend_pkg::*;

  localparam int              PRF_COUNT   = 64;
  localparam int              PRF_WIDTH   = $clog2(PRF_COUNT);
  localparam logic [XLEN-1:0] BOOT_PC     = '0;
  localparam int              OUT_W       = XLEN + 3 + 4 * PRF_WIDTH; // Bundle of ren outputs
  localparam int              NUM_INSTR   = 3000;
  localparam int              CYCLE_LIMIT = NUM_INSTR * 6 + 2000;     // Slow CPI plus drain
  localparam int              DRAIN_START = 1000; // Retirement withheld from here
  localparam int              DRAIN_LEN   = 200;

  logic                 clk;
  logic                 rst_n;
  logic [XLEN-1:0]      imem_data;
  logic                 dispatch_ready;
  logic                 flush;
  logic [XLEN-1:0]      flush_pc;
  logic                 retire_valid;
  logic [PRF_WIDTH-1:0] retire_preg;
  logic [XLEN-1:0]      imem_addr;
  logic                 ren_valid;
  logic [XLEN-1:0]      ren_pc;
  opcode_e              ren_opcode;
  logic [PRF_WIDTH-1:0] ren_prd;
  logic [PRF_WIDTH-1:0] ren_prs1;
  logic [PRF_WIDTH-1:0] ren_prs2;
  logic [PRF_WIDTH-1:0] ren_pold;

  logic [XLEN-1:0]      imem [1024];  // Word addressed image of 4 KB
  logic [31:0]          lcg_state;
  logic [PRF_WIDTH-1:0] retire_q [$]; // Old mappings waiting to retire
  logic [XLEN-1:0]      expected_pc;  // Next consumed pc
  logic                 hold_check;   // Outputs must repeat this cycle
  logic [OUT_W-1:0]     held_outputs;
  int                   mismatch_count;
  int                   other_count;
  int                   consumed;
  int                   cycle;
  int                   drain_empty;  // Cycles with the model list empty

  `include "rename_model.svh"

  rename_frontend dut (.*);

  assign imem_data = imem[imem_addr[11:2]]; // Combinational memory

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [OUT_W-1:0] output_bundle();
    return {ren_pc, ren_opcode, ren_prd, ren_prs1, ren_prs2, ren_pold};
  endfunction

  task automatic log_mismatch(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
    mismatch_count++;
    $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic fill_imem();
    logic [31:0] hi;
    logic [31:0] lo;
    logic [6:0]  major;
    for (int w = 0; w < 1024; w++) begin
      hi = next_rand();
      lo = next_rand();
      case (hi[31:29])
        3'd0:    major = 7'h33;
        3'd1:    major = 7'h13;
        3'd2:    major = 7'h03;
        3'd3:    major = 7'h23;
        3'd4:    major = 7'h63;
        3'd5:    major = 7'h37;
        3'd6:    major = 7'h6f;
        default: major = lo[6:0]; // Mostly unknown codes
      endcase
      imem[w] = {hi[27:12], lo[31:23], major};
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    logic        retire_ok;
    r         = next_rand();
    retire_ok = (cycle < DRAIN_START) || (cycle >= DRAIN_START + DRAIN_LEN);
    dispatch_ready <= (r[31:29] != 3'd0);       // Ready 7 of 8 cycles
    flush          <= (r[28:23] == 6'd0);       // About one in 64
    flush_pc       <= {20'd0, r[19:10], 2'b00}; // Aligned word inside the image
    if (retire_ok && retire_q.size() > 0 && r[22:21] != 2'd0) begin
      retire_valid <= 1'b1;
      retire_preg  <= retire_q.pop_front();
    end else begin
      retire_valid <= 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // Per-edge checks against the model
  ////////////////////////////////////////

  task automatic check_cycle();
    logic [XLEN-1:0]      instr;
    logic                 writes;
    logic [ARF_WIDTH-1:0] rd;
    logic [PRF_WIDTH-1:0] exp_prd;
    logic [PRF_WIDTH-1:0] exp_pold;
    instr    = imem[expected_pc[11:2]];
    writes   = model_writes(instr);
    rd       = instr[11:7];
    exp_prd  = '0;
    exp_pold = writes ? model_rat[rd] : '0;
    if (hold_check) begin
      assert (ren_valid && output_bundle() == held_outputs)
        else log_mismatch("outputs under back-pressure", output_bundle(), held_outputs);
    end
    hold_check   = ren_valid && !dispatch_ready && !flush;
    held_outputs = output_bundle();
    if (ren_valid && (dispatch_ready || flush)) begin // Renamed whether consumed or dropped
      assert (ren_pc == expected_pc) else log_mismatch("pc", ren_pc, expected_pc);
      assert (ren_opcode == model_class(instr))
        else log_mismatch("opcode", ren_opcode, model_class(instr));
      assert (ren_prs1 == model_rat[instr[19:15]])
        else log_mismatch("prs1", ren_prs1, model_rat[instr[19:15]]);
      assert (ren_prs2 == model_rat[instr[24:20]])
        else log_mismatch("prs2", ren_prs2, model_rat[instr[24:20]]);
      assert (!writes || model_free.size() > 0) else begin
        other_count++;
        $display("Writing instruction at pc %h got a register the model list lacks", ren_pc);
      end
      if (writes && model_free.size() > 0) begin
        exp_prd       = model_free.pop_front(); // Allocation follows retire order
        model_rat[rd] = exp_prd;
        retire_q.push_back(exp_pold);
      end
      assert (ren_prd == exp_prd) else log_mismatch("prd", ren_prd, exp_prd);
      assert (ren_pold == exp_pold) else log_mismatch("pold", ren_pold, exp_pold);
      expected_pc = expected_pc + 32'd4;
      if (dispatch_ready) begin
        consumed++;
      end
    end
    if (flush) begin
      expected_pc = flush_pc; // Redirect
    end
    if (retire_valid) begin
      model_free.push_back(retire_preg);
    end
    if (model_free.size() == 0) begin
      drain_empty++;
    end
  endtask

  initial begin
    lcg_state      = 32'h93ad_b48b;
    rst_n          = 1'b0;
    dispatch_ready = 1'b0;
    flush          = 1'b0;
    flush_pc       = '0;
    retire_valid   = 1'b0;
    retire_preg    = '0;
    hold_check     = 1'b0;
    held_outputs   = '0;
    mismatch_count = 0;
    other_count    = 0;
    consumed       = 0;
    cycle          = 0;
    drain_empty    = 0;
    expected_pc    = BOOT_PC;
    fill_imem();
    model_reset();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (ren_valid == 1'b0) else log_mismatch("ren_valid after reset", ren_valid, 0);
    while (consumed < NUM_INSTR && cycle < CYCLE_LIMIT) begin
      drive_inputs();
      @(posedge clk);
      cycle++;
      check_cycle();
    end
    if (consumed < NUM_INSTR) begin
      other_count++;
      $display("Timeout: %0d of %0d instructions consumed in %0d cycles",
               consumed, NUM_INSTR, cycle);
    end
    assert (drain_empty > 0) else begin
      other_count++;
      $display("Free list never ran empty while retirement was withheld");
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+test
rtl/frontend_pkg.sv
rtl/rename_bus_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/free_list.sv
rtl/rename_stage.sv
rtl/rename_frontend.sv
test/tb_rename_frontend.sv

// ==== Bender.yml ====
package:
  name: rename_frontend

sources:
  - files:
      - rtl/frontend_pkg.sv
      - rtl/rename_bus_if.sv
      - rtl/fetch_stage.sv
      - rtl/decode_stage.sv
      - rtl/free_list.sv
      - rtl/rename_stage.sv
      - rtl/rename_frontend.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_rename_frontend.sv
